// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mdu_issue_unit
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mdu_iq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_iq_ctrl
    import mdu_iq_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               flush,
    input  logic                               enq_req,
    input  mdu_entry_t                         enq_data,
    input  logic                               busy_enq_l,
    input  logic                               busy_enq_r,
    input  logic                               deq_req,
    input  logic [queue_idx_w-1:0]             deq_idx,
    output slot_ctrl_t [queue_len-1:0]         slot_ctrl,
    output mdu_entry_t                         enq_entry,
    output logic [queue_len-1:0]               valid_vec,
    output logic                               full
);

    logic [tail_w-1:0] tail;
    logic [tail_w-1:0] base;   // tail once this cycle's dequeue is taken out
    logic              enq_ok;

    assign full   = (tail == tail_w'(queue_len));
    assign enq_ok = enq_req & ~full; // dropped while full even with a dequeue
    assign base   = tail - tail_w'(deq_req);

    // thermometer valid and per-slot load/shift enables
    always_comb begin
        for (int i = 0; i < queue_len; i++) begin
            valid_vec[i]        = (tail > tail_w'(i));
            slot_ctrl[i].enq_en = enq_ok && (base == tail_w'(i));
            slot_ctrl[i].cmp_en = deq_req && (deq_idx <= queue_idx_w'(i));
        end
    end

    // dispatch may already know a source is ready; otherwise ask the scoreboard
    always_comb begin
        enq_entry      = enq_data;
        enq_entry.rdy1 = enq_data.rdy1 | ~busy_enq_l;
        enq_entry.rdy2 = enq_data.rdy2 | ~busy_enq_r;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else begin
            tail <= base + tail_w'(enq_ok);
        end
    end

    // counter must stay in 0..queue_len across any enq/deq mix
    a_tail_range: assert property (
        @(posedge clk) disable iff (rst)
        tail <= tail_w'(queue_len)
    ) else $error("mdu_iq_ctrl: tail %0d beyond queue length", tail);

    // selector must only pick occupied slots
    a_deq_valid: assert property (
        @(posedge clk) disable iff (rst || flush)
        deq_req |-> valid_vec[deq_idx]
    ) else $error("mdu_iq_ctrl: dequeue of empty slot %0d", deq_idx);

endmodule

`default_nettype wire

// File: mdu_iq_entry.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_iq_entry
    import mdu_iq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  slot_ctrl_t ctrl,
    input  mdu_entry_t enq_entry,
    input  mdu_entry_t up_entry,
    input  logic       up_rdy1,
    input  logic       up_rdy2,
    input  logic       busy_l,
    input  logic       busy_r,
    output mdu_entry_t entry,
    output logic       rdy1_next,
    output logic       rdy2_next,
    output logic       ready,
    output logic       is_mul
);

    mdu_entry_t nxt;

    // refreshed readiness of the current content also feeds the slot below
    assign rdy1_next = ~busy_l;
    assign rdy2_next = ~busy_r;

    always_comb begin
        if (ctrl.enq_en) begin
            nxt = enq_entry; // wins over a shift into the same slot
        end else if (ctrl.cmp_en) begin
            nxt      = up_entry;
            nxt.rdy1 = up_rdy1;
            nxt.rdy2 = up_rdy2;
        end else begin
            nxt      = entry;
            nxt.rdy1 = rdy1_next;
            nxt.rdy2 = rdy2_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entry <= '0;
        end else begin
            entry <= nxt;
        end
    end

    assign ready  = entry.rdy1 & entry.rdy2;
    assign is_mul = entry.is_mul;

endmodule

`default_nettype wire

// File: mdu_iq_pkg.sv
`default_nettype none

package mdu_iq_pkg;

    // queue geometry
    localparam int queue_len   = 8;
    localparam int queue_idx_w = 3;
    localparam int tail_w      = 4;   // holds 0..queue_len

    // register and tag widths
    localparam int preg_w = 6;
    localparam int rob_w  = 5;

    localparam int func_w = 3;

    typedef logic [preg_w-1:0] preg_t;

    // payload that rides through the queue untouched
    typedef struct packed {
        preg_t              pdst;
        preg_t              prs1;
        preg_t              prs2;
        logic [func_w-1:0]  func;    // not decoded here
        logic [rob_w-1:0]   rob_idx;
    } mdu_uop_t;

    // one slot's content
    typedef struct packed {
        mdu_uop_t uop;
        logic     rdy1;   // prs1 available
        logic     rdy2;   // prs2 available
        logic     is_mul; // 0 routes to the divider
    } mdu_entry_t;

    // per-slot control from the queue controller
    typedef struct packed {
        logic enq_en; // load from the enqueue port
        logic cmp_en; // take the neighbor above
    } slot_ctrl_t;

endpackage

`default_nettype wire

// File: mdu_issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_issue_select
    import mdu_iq_pkg::*;
(
    input  mdu_entry_t [queue_len-1:0] entries,
    input  logic [queue_len-1:0]       valid_vec,
    input  logic [queue_len-1:0]       ready_vec,
    input  logic [queue_len-1:0]       is_mul_vec,
    input  logic                       mul_busy,
    input  logic                       div_busy,
    output logic                       issue_en,
    output logic [queue_idx_w-1:0]     issue_idx,
    output mdu_uop_t                   issue_uop
);

    logic [queue_len-1:0] unit_free;
    logic [queue_len-1:0] cand;

    // each slot only cares about its own unit
    always_comb begin
        for (int i = 0; i < queue_len; i++) begin
            unit_free[i] = is_mul_vec[i] ? ~mul_busy : ~div_busy;
        end
    end

    assign cand     = valid_vec & ready_vec & unit_free;
    assign issue_en = |cand;

    // scan down so the lowest (oldest) candidate is written last
    always_comb begin
        issue_idx = '0;
        for (int i = queue_len - 1; i >= 0; i--) begin
            if (cand[i]) begin
                issue_idx = queue_idx_w'(i);
            end
        end
    end

    assign issue_uop = entries[issue_idx].uop;

    // uses the stored readiness and unit fields rather than the summary vectors
    always_comb begin
        if (issue_en) begin
            a_issue_legal: assert final (
                valid_vec[issue_idx] &&
                entries[issue_idx].rdy1 && entries[issue_idx].rdy2 &&
                !(entries[issue_idx].is_mul ? mul_busy : div_busy)
            ) else $error("mdu_issue_select: illegal issue from slot %0d", issue_idx);
        end
    end

endmodule

`default_nettype wire

// File: mdu_issue_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_issue_unit
    import mdu_iq_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     enq_req,
    input  mdu_entry_t               enq_data,
    input  logic                     mul_busy,
    input  logic                     div_busy,
    input  logic [queue_len:0]       busy_l,
    input  logic [queue_len:0]       busy_r,
    output logic                     ready,
    output logic                     issue_en,
    output mdu_uop_t                 issue_uop,
    output preg_t [queue_len:0]      rd_num_l,
    output preg_t [queue_len:0]      rd_num_r
);

    slot_ctrl_t [queue_len-1:0] slot_ctrl;
    mdu_entry_t                 enq_entry;
    mdu_entry_t [queue_len:0]   slot_q;     // top index is the empty filler
    logic [queue_len:0]         rdy1_nx;
    logic [queue_len:0]         rdy2_nx;
    logic [queue_len-1:0]       valid_vec;
    logic [queue_len-1:0]       ready_vec;
    logic [queue_len-1:0]       is_mul_vec;
    logic [queue_idx_w-1:0]     issue_idx;
    logic                       full;

    assign ready = ~full;

    // nothing above the last slot
    assign slot_q[queue_len]  = '0;
    assign rdy1_nx[queue_len] = 1'b0;
    assign rdy2_nx[queue_len] = 1'b0;

    // enqueue port lookup sits at the top index
    assign rd_num_l[queue_len] = enq_data.uop.prs1;
    assign rd_num_r[queue_len] = enq_data.uop.prs2;

    mdu_iq_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .enq_req    (enq_req),
        .enq_data   (enq_data),
        .busy_enq_l (busy_l[queue_len]),
        .busy_enq_r (busy_r[queue_len]),
        .deq_req    (issue_en),
        .deq_idx    (issue_idx),
        .slot_ctrl  (slot_ctrl),
        .enq_entry  (enq_entry),
        .valid_vec  (valid_vec),
        .full       (full)
    );

    for (genvar i = 0; i < queue_len; i++) begin : g_slot
        mdu_iq_entry u_entry (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),
            .ctrl      (slot_ctrl[i]),
            .enq_entry (enq_entry),
            .up_entry  (slot_q[i+1]),
            .up_rdy1   (rdy1_nx[i+1]),
            .up_rdy2   (rdy2_nx[i+1]),
            .busy_l    (busy_l[i]),
            .busy_r    (busy_r[i]),
            .entry     (slot_q[i]),
            .rdy1_next (rdy1_nx[i]),
            .rdy2_next (rdy2_nx[i]),
            .ready     (ready_vec[i]),
            .is_mul    (is_mul_vec[i])
        );

        assign rd_num_l[i] = slot_q[i].uop.prs1;
        assign rd_num_r[i] = slot_q[i].uop.prs2;
    end

    mdu_issue_select u_select (
        .entries    (slot_q[queue_len-1:0]),
        .valid_vec  (valid_vec),
        .ready_vec  (ready_vec),
        .is_mul_vec (is_mul_vec),
        .mul_busy   (mul_busy),
        .div_busy   (div_busy),
        .issue_en   (issue_en),
        .issue_idx  (issue_idx),
        .issue_uop  (issue_uop)
    );

endmodule

`default_nettype wire

// File: tb.f
mdu_iq_pkg.sv
mdu_iq_ctrl.sv
mdu_iq_entry.sv
mdu_issue_select.sv
mdu_issue_unit.sv
tb_mdu_issue_unit.sv

// File: tb_mdu_issue_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mdu_issue_unit
    import mdu_iq_pkg::*;
();

    localparam int          clk_period = 20;
    localparam int          rst_cycles = 4;
    localparam int unsigned seed       = 32'h340c_f44c;

    // one cycle of stimulus and the outputs expected in that cycle
    typedef struct packed {
        logic [5:0] id;        // 0 means no enqueue
        logic       is_mul;
        preg_t      prs1;
        preg_t      prs2;
        logic       flush;
        logic       mul_busy;
        logic       div_busy;
        preg_t      set_reg;   // 0 means none
        preg_t      clr_reg;
        logic       exp_ready;
        logic [5:0] exp_id;    // expected issuer or 0 for none
    } row_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                flush;
    logic                enq_req;
    mdu_entry_t          enq_data;
    logic                mul_busy;
    logic                div_busy;
    logic [queue_len:0]  busy_l;
    logic [queue_len:0]  busy_r;
    logic                ready;
    logic                issue_en;
    mdu_uop_t            issue_uop;
    preg_t [queue_len:0] rd_num_l;
    preg_t [queue_len:0] rd_num_r;

    logic [63:0] sb_busy;   // scoreboard busy bit per physical register
    row_t        rows[$];
    mdu_uop_t    uop_by_id[64];
    int          n_rows;
    int          n_checks = 0;
    int          n_errors = 0;
    bit          table_done = 1'b0;

    mdu_issue_unit mdu_issue_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .enq_req   (enq_req),
        .enq_data  (enq_data),
        .mul_busy  (mul_busy),
        .div_busy  (div_busy),
        .busy_l    (busy_l),
        .busy_r    (busy_r),
        .ready     (ready),
        .issue_en  (issue_en),
        .issue_uop (issue_uop),
        .rd_num_l  (rd_num_l),
        .rd_num_r  (rd_num_r)
    );

    always #(clk_period / 2) clk = ~clk;

    // scoreboard answers in the same cycle
    always_comb begin
        for (int i = 0; i <= queue_len; i++) begin
            busy_l[i] = sb_busy[rd_num_l[i]];
            busy_r[i] = sb_busy[rd_num_r[i]];
        end
    end

    task automatic add_row(input int id, mul, p1, p2, fl, mb, db, set_r, clr_r, rdy, exp_id);
        row_t r;
        r.id        = 6'(id);
        r.is_mul    = 1'(mul);
        r.prs1      = preg_t'(p1);
        r.prs2      = preg_t'(p2);
        r.flush     = 1'(fl);
        r.mul_busy  = 1'(mb);
        r.div_busy  = 1'(db);
        r.set_reg   = preg_t'(set_r);
        r.clr_reg   = preg_t'(clr_r);
        r.exp_ready = 1'(rdy);
        r.exp_id    = 6'(exp_id);
        rows.push_back(r);
        if (id != 0) begin
            uop_by_id[id].pdst    = preg_t'($urandom);
            uop_by_id[id].prs1    = preg_t'(p1);
            uop_by_id[id].prs2    = preg_t'(p2);
            uop_by_id[id].func    = (mul != 0) ? 3'b000 : 3'b100;
            uop_by_id[id].rob_idx = rob_w'($urandom);
        end
    endtask

    task automatic build_table();
        //       id mul p1  p2 fl mb db set clr rdy exp
        // back-to-back ready entries
        add_row( 1, 1,  1,  2, 0, 0, 0,  0,  0, 1,  0);
        add_row( 2, 0,  3,  4, 0, 0, 0,  0,  0, 1,  1);
        add_row( 3, 1,  5,  6, 0, 0, 0,  0,  0, 1,  2);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  3);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  0);
        // left source busy while a younger divide goes first
        add_row( 4, 1,  7,  8, 0, 0, 0,  7,  0, 1,  0);
        add_row( 5, 0,  9, 10, 0, 0, 0,  0,  0, 1,  0);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  5);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  7, 1,  0);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  4);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  0);
        // multiplier busy
        add_row( 6, 1, 11, 12, 0, 1, 0,  0,  0, 1,  0);
        add_row( 7, 0, 13, 14, 0, 1, 0,  0,  0, 1,  0);
        add_row( 0, 0,  0,  0, 0, 1, 0,  0,  0, 1,  7);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  6);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  0);
        // divider busy
        add_row( 8, 0, 15, 16, 0, 0, 1,  0,  0, 1,  0);
        add_row( 9, 1, 17, 18, 0, 0, 1,  0,  0, 1,  0);
        add_row( 0, 0,  0,  0, 0, 0, 1,  0,  0, 1,  9);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  8);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  0);
        // eight waiting entries fill the queue
        add_row(10, 1, 20, 21, 0, 0, 0, 20,  0, 1,  0);
        add_row(11, 0, 20, 22, 0, 0, 0,  0,  0, 1,  0);
        add_row(12, 1, 20, 23, 0, 0, 0,  0,  0, 1,  0);
        add_row(13, 0, 20, 24, 0, 0, 0,  0,  0, 1,  0);
        add_row(14, 1, 20, 25, 0, 0, 0,  0,  0, 1,  0);
        add_row(15, 0, 20, 26, 0, 0, 0,  0,  0, 1,  0);
        add_row(16, 1, 20, 27, 0, 0, 0,  0,  0, 1,  0);
        add_row(17, 0, 20, 28, 0, 0, 0,  0,  0, 1,  0);
        add_row(18, 1, 20, 30, 0, 0, 0,  0,  0, 0,  0);   // dropped
        add_row( 0, 0,  0,  0, 0, 0, 0,  0, 20, 0,  0);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 0, 10);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 11);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 12);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 13);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 14);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 15);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 16);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 17);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  0);
        // flush as both waiting entries wake up
        add_row(19, 1, 40, 41, 0, 0, 0, 40,  0, 1,  0);
        add_row(20, 0, 40, 42, 0, 0, 0,  0,  0, 1,  0);
        add_row( 0, 0,  0,  0, 1, 0, 0,  0, 40, 1,  0);
        add_row(21, 1, 43, 44, 0, 0, 0,  0,  0, 1,  0);
        add_row(22, 0, 45, 46, 0, 0, 0,  0,  0, 1, 21);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 22);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  0);
        // right source busy when it reaches the enqueue port
        add_row(23, 0, 50, 51, 0, 0, 0, 51,  0, 1,  0);
        add_row(24, 1, 52, 53, 0, 0, 0,  0,  0, 1,  0);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 24);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0, 51, 1,  0);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1, 23);
        add_row( 0, 0,  0,  0, 0, 0, 0,  0,  0, 1,  0);
    endtask

    function automatic mdu_entry_t entry_for(input row_t r);
        mdu_entry_t e;
        e = '0;   // dispatch claims no readiness
        if (r.id != 6'd0) begin
            e.uop    = uop_by_id[r.id];
            e.is_mul = r.is_mul;
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t: %s got 0x%0h, expected 0x%0h",
                     $time, name, got, exp);
        end
    endtask

    task automatic check_outputs(input row_t r);
        mdu_uop_t exp_uop;
        exp_uop = uop_by_id[r.exp_id];
        check_value("ready", 32'(ready), 32'(r.exp_ready));
        check_value("issue_en", 32'(issue_en), 32'(r.exp_id != 6'd0));
        if (r.exp_id != 6'd0) begin
            check_value("issue_uop.rob_idx", 32'(issue_uop.rob_idx), 32'(exp_uop.rob_idx));
            check_value("issue_uop", 32'(issue_uop), 32'(exp_uop));
        end
        // lookup slot of the enqueue port
        if (r.id != 6'd0) begin
            check_value("rd_num_l[queue_len]", 32'(rd_num_l[queue_len]), 32'(r.prs1));
            check_value("rd_num_r[queue_len]", 32'(rd_num_r[queue_len]), 32'(r.prs2));
        end
    endtask

    initial begin
        rst        = 1'b1;
        flush      = 1'b0;
        enq_req    = 1'b0;
        enq_data   = '0;
        mul_busy   = 1'b0;
        div_busy   = 1'b0;
        sb_busy    = '0;
        void'($urandom(seed));
        build_table();
        n_rows     = rows.size();
        table_done = 1'b1;

        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;

        foreach (rows[k]) begin
            @(posedge clk);
            enq_req  <= (rows[k].id != 6'd0);
            enq_data <= entry_for(rows[k]);
            flush    <= rows[k].flush;
            mul_busy <= rows[k].mul_busy;
            div_busy <= rows[k].div_busy;
            if (rows[k].set_reg != '0) begin
                sb_busy[rows[k].set_reg] <= 1'b1;
            end
            if (rows[k].clr_reg != '0) begin
                sb_busy[rows[k].clr_reg] <= 1'b0;
            end
            @(negedge clk);
            check_outputs(rows[k]);
        end

        $display("rows: %0d  checks: %0d  errors: %0d", n_rows, n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog at four times the table length
    initial begin
        wait (table_done);
        #(n_rows * clk_period * 4);
        $display("timeout: the stimulus table did not finish within %0d cycles", n_rows * 4);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
